//--- verilog/bus_pkg.sv
// shared widths, ids and encodings of the two-core memory bus
// two cores only; timer region is any address with bit 31 set
`default_nettype none

package bus_pkg;

    // byte address and data word on the shared bus
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // index of the granted core
    typedef logic [0:0] core_id_t;

    localparam int NCORES = 2;

    // timer region base, only bit 31 is decoded
    localparam addr_t TIMER_BASE = 32'h8000_0000;

    // word offsets inside the timer region
    // mtime is read-only, a write to it is dropped
    localparam logic [3:0] TIMER_MTIME_LO = 4'h0;
    localparam logic [3:0] TIMER_MTIME_HI = 4'h4;
    localparam logic [3:0] TIMER_CMP_LO   = 4'h8;
    localparam logic [3:0] TIMER_CMP_HI   = 4'hc;

    // decoded access target
    typedef enum logic {
        TGT_RAM,
        TGT_TIMER
    } target_t;

    // time-slice arbiter states
    typedef enum logic [1:0] {
        ARB_SERVE,
        ARB_HANDOFF,
        ARB_SETTLE,
        ARB_RUN
    } arb_state_t;

endpackage

`default_nettype wire

//--- verilog/bus_arbiter.sv
// time-slice arbiter; grant moves only when the owner is idle with no open transfer
// SLOT_CYCLES must be at least 1
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter
    import bus_pkg::*;
#(
    parameter int SLOT_CYCLES = 4
) (
    input  wire      CLK,
    input  wire      RST_X,
    input  wire      idle_0,
    input  wire      idle_1,
    input  wire      xfer_open,
    output core_id_t grant,
    output logic     switching
);

    localparam int CNT_W = (SLOT_CYCLES > 1) ? $clog2(SLOT_CYCLES) : 1;
    localparam logic [CNT_W-1:0] SLOT_LAST = CNT_W'(SLOT_CYCLES - 1);

    arb_state_t       state;
    logic [CNT_W-1:0] slot_cnt;
    logic             grant_idle;
    core_id_t         next_grant;

    // only the owner's idle flag matters
    assign grant_idle = (grant == core_id_t'(0)) ? idle_0 : idle_1;

    // round robin over the cores
    assign next_grant = (grant == core_id_t'(NCORES - 1)) ? core_id_t'(0)
                                                          : grant + core_id_t'(1);

    // both cores see busy while the grant changes hands
    assign switching = (state == ARB_HANDOFF) || (state == ARB_SETTLE);

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            state    <= ARB_SERVE;
            grant    <= core_id_t'(0);
            slot_cnt <= '0;
        end else begin
            case (state)
                ARB_SERVE: begin
                    // never pull the grant from under a transfer
                    if (grant_idle && !xfer_open) begin
                        state <= ARB_HANDOFF;
                    end
                end
                ARB_HANDOFF: begin
                    // old owner is already busy, hand over now
                    grant <= next_grant;
                    state <= ARB_SETTLE;
                end
                ARB_SETTLE: begin
                    // new owner still busy for this cycle
                    slot_cnt <= '0;
                    state    <= ARB_RUN;
                end
                ARB_RUN: begin
                    // guaranteed window, idle is not looked at here
                    if (slot_cnt == SLOT_LAST) begin
                        state <= ARB_SERVE;
                    end else begin
                        slot_cnt <= slot_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ARB_SERVE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/bus_decode.sv
// selects the granted core's request and splits its address
// RAM index bits above log2(RAM_WORDS)+1 are ignored, so RAM aliases
`timescale 1ns/10ps
`default_nettype none

module bus_decode
    import bus_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  core_id_t                       grant,
    input  wire                            req_0,
    input  wire                            we_0,
    input  addr_t                          addr_0,
    input  data_t                          wdata_0,
    input  wire                            req_1,
    input  wire                            we_1,
    input  addr_t                          addr_1,
    input  data_t                          wdata_1,
    output logic                           bus_req,
    output logic                           bus_we,
    output data_t                          bus_wdata,
    output target_t                        target,
    output logic [$clog2(RAM_WORDS)-1:0]   word_index,
    output logic [3:0]                     timer_offset
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    addr_t sel_addr;

    // the other core's request is simply not selected
    always_comb begin
        if (grant == core_id_t'(0)) begin
            bus_req   = req_0;
            bus_we    = we_0;
            bus_wdata = wdata_0;
            sel_addr  = addr_0;
        end else begin
            bus_req   = req_1;
            bus_we    = we_1;
            bus_wdata = wdata_1;
            sel_addr  = addr_1;
        end
    end

    assign target = ((sel_addr & TIMER_BASE) != '0) ? TGT_TIMER : TGT_RAM;

    // word addressed, byte offset bits dropped
    assign word_index   = sel_addr[IDX_W+1:2];
    assign timer_offset = sel_addr[3:0];

endmodule

`default_nettype wire

//--- verilog/bus_execute.sv
// word RAM and machine timer behind the four-phase handshake
// one access per req pulse; ack rises one edge after req, falls one edge after req drops
`timescale 1ns/10ps
`default_nettype none

module bus_execute
    import bus_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  wire                            CLK,
    input  wire                            RST_X,
    input  wire                            bus_req,
    input  wire                            bus_we,
    input  data_t                          bus_wdata,
    input  target_t                        target,
    input  wire [$clog2(RAM_WORDS)-1:0]    word_index,
    input  wire [3:0]                      timer_offset,
    output logic                           bus_ack,
    output data_t                          bus_rdata,
    output logic                           xfer_open,
    output logic                           timer_irq
);

    data_t       ram [RAM_WORDS];
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        access;
    data_t       timer_rd;

    // a new request is taken only while ack is still low
    assign access = bus_req && !bus_ack;

    assign xfer_open = bus_req || bus_ack;

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            bus_ack <= 1'b0;
        end else if (access) begin
            bus_ack <= 1'b1;
        end else if (!bus_req) begin
            bus_ack <= 1'b0;
        end
    end

    // unknown timer offsets read as zero
    always_comb begin
        case (timer_offset)
            TIMER_MTIME_LO: timer_rd = mtime[31:0];
            TIMER_MTIME_HI: timer_rd = mtime[63:32];
            TIMER_CMP_LO:   timer_rd = mtimecmp[31:0];
            TIMER_CMP_HI:   timer_rd = mtimecmp[63:32];
            default:        timer_rd = '0;
        endcase
    end

    // read data is captured at the ack edge and held until the next access
    always_ff @(posedge CLK) begin
        if (access) begin
            if (target == TGT_RAM) begin
                bus_rdata <= ram[word_index];
                if (bus_we) begin
                    ram[word_index] <= bus_wdata;
                end
            end else begin
                bus_rdata <= timer_rd;
            end
        end
    end

    // mtime free runs; only the compare halves take writes
    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            mtime <= mtime + 64'd1;
            if (access && bus_we && (target == TGT_TIMER)) begin
                if (timer_offset == TIMER_CMP_LO) begin
                    mtimecmp[31:0] <= bus_wdata;
                end else if (timer_offset == TIMER_CMP_HI) begin
                    mtimecmp[63:32] <= bus_wdata;
                end
            end
        end
    end

    // irq follows the compare one cycle late
    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);
        end
    end

endmodule

`default_nettype wire

//--- verilog/bus_result.sv
// returns ack, read data and busy to the granted core only
// the other core sees zeros and a permanent busy
`timescale 1ns/10ps
`default_nettype none

module bus_result
    import bus_pkg::*;
(
    input  core_id_t grant,
    input  wire      switching,
    input  wire      bus_ack,
    input  data_t    bus_rdata,
    output logic     ack_0,
    output logic     ack_1,
    output data_t    rdata_0,
    output data_t    rdata_1,
    output logic     busy_0,
    output logic     busy_1
);

    always_comb begin
        if (grant == core_id_t'(0)) begin
            ack_0   = bus_ack;
            rdata_0 = bus_rdata;
            busy_0  = switching;
            ack_1   = 1'b0;
            rdata_1 = '0;
            busy_1  = 1'b1;
        end else begin
            ack_1   = bus_ack;
            rdata_1 = bus_rdata;
            busy_1  = switching;
            // core 0 is parked until the next handoff
            ack_0   = 1'b0;
            rdata_0 = '0;
            busy_0  = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/shared_bus_top.sv
// two-core shared bus with time-slice arbitration, word RAM and machine timer
// RAM_WORDS must be a power of two, SLOT_CYCLES at least 1
`timescale 1ns/10ps
`default_nettype none

module shared_bus_top
    import bus_pkg::*;
#(
    parameter int RAM_WORDS   = 256,
    parameter int SLOT_CYCLES = 4
) (
    input  wire   CLK,
    input  wire   RST_X,
    input  wire   req_0,
    input  wire   we_0,
    input  addr_t addr_0,
    input  data_t wdata_0,
    input  wire   idle_0,
    input  wire   req_1,
    input  wire   we_1,
    input  addr_t addr_1,
    input  data_t wdata_1,
    input  wire   idle_1,
    output logic  ack_0,
    output data_t rdata_0,
    output logic  busy_0,
    output logic  ack_1,
    output data_t rdata_1,
    output logic  busy_1,
    output logic  timer_irq
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    core_id_t         grant;
    logic             switching;
    logic             xfer_open;
    logic             bus_req;
    logic             bus_we;
    data_t            bus_wdata;
    target_t          target;
    logic [IDX_W-1:0] word_index;
    logic [3:0]       timer_offset;
    logic             bus_ack;
    data_t            bus_rdata;

    bus_arbiter #(
        .SLOT_CYCLES (SLOT_CYCLES)
    ) u_arbiter (
        .CLK       (CLK),
        .RST_X     (RST_X),
        .idle_0    (idle_0),
        .idle_1    (idle_1),
        .xfer_open (xfer_open),
        .grant     (grant),
        .switching (switching)
    );

    bus_decode #(
        .RAM_WORDS (RAM_WORDS)
    ) u_decode (
        .grant        (grant),
        .req_0        (req_0),
        .we_0         (we_0),
        .addr_0       (addr_0),
        .wdata_0      (wdata_0),
        .req_1        (req_1),
        .we_1         (we_1),
        .addr_1       (addr_1),
        .wdata_1      (wdata_1),
        .bus_req      (bus_req),
        .bus_we       (bus_we),
        .bus_wdata    (bus_wdata),
        .target       (target),
        .word_index   (word_index),
        .timer_offset (timer_offset)
    );

    bus_execute #(
        .RAM_WORDS (RAM_WORDS)
    ) u_execute (
        .CLK          (CLK),
        .RST_X        (RST_X),
        .bus_req      (bus_req),
        .bus_we       (bus_we),
        .bus_wdata    (bus_wdata),
        .target       (target),
        .word_index   (word_index),
        .timer_offset (timer_offset),
        .bus_ack      (bus_ack),
        .bus_rdata    (bus_rdata),
        .xfer_open    (xfer_open),
        .timer_irq    (timer_irq)
    );

    bus_result u_result (
        .grant     (grant),
        .switching (switching),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata),
        .ack_0     (ack_0),
        .ack_1     (ack_1),
        .rdata_0   (rdata_0),
        .rdata_1   (rdata_1),
        .busy_0    (busy_0),
        .busy_1    (busy_1)
    );

endmodule

`default_nettype wire

//--- bench/shared_bus_checker.sv
// bus protocol assertions, bound into shared_bus_top
// handshake checks look at the internal bus, not at the core ports
`timescale 1ns/10ps
`default_nettype none

module shared_bus_checker
    import bus_pkg::*;
(
    input wire      CLK,
    input wire      RST_X,
    input core_id_t grant,
    input wire      switching,
    input wire      xfer_open,
    input wire      bus_req,
    input wire      bus_ack,
    input wire      ack_0,
    input wire      ack_1,
    input data_t    rdata_0,
    input data_t    rdata_1,
    input wire      busy_0,
    input wire      busy_1
);

    int fail_count = 0;

    // at most one core may own the bus
    a_exclusive: assert property (@(posedge CLK) disable iff (!RST_X) busy_0 || busy_1)
        else begin
            $error("both cores saw busy low");
            fail_count++;
        end
    a_park_0: assert property (@(posedge CLK) disable iff (!RST_X)
        (grant == core_id_t'(1)) |-> (!ack_0 && rdata_0 == '0))
        else begin
            $error("parked core 0 saw ack or data");
            fail_count++;
        end
    a_park_1: assert property (@(posedge CLK) disable iff (!RST_X)
        (grant == core_id_t'(0)) |-> (!ack_1 && rdata_1 == '0))
        else begin
            $error("parked core 1 saw ack or data");
            fail_count++;
        end

    // four-phase handshake timing
    a_ack_rise: assert property (@(posedge CLK) disable iff (!RST_X)
        (bus_req && !bus_ack) |=> bus_ack)
        else begin
            $error("ack did not follow req by one edge");
            fail_count++;
        end
    // req may already be gone when the new ack is sampled
    a_ack_req: assert property (@(posedge CLK) disable iff (!RST_X)
        $rose(bus_ack) |-> $past(bus_req))
        else begin
            $error("ack rose without req");
            fail_count++;
        end
    a_ack_fall: assert property (@(posedge CLK) disable iff (!RST_X)
        (!bus_req && bus_ack) |=> !bus_ack)
        else begin
            $error("ack did not fall one edge after req");
            fail_count++;
        end

    // handoff lasts two cycles and never starts over an open transfer
    a_handoff: assert property (@(posedge CLK) disable iff (!RST_X)
        $rose(switching) |=> switching ##1 !switching)
        else begin
            $error("handoff was not two cycles long");
            fail_count++;
        end
    a_no_mid: assert property (@(posedge CLK) disable iff (!RST_X)
        $rose(switching) |-> !$past(xfer_open))
        else begin
            $error("handoff started during a transfer");
            fail_count++;
        end

endmodule

bind shared_bus_top shared_bus_checker chk (
    .CLK (CLK), .RST_X (RST_X), .grant (grant), .switching (switching),
    .xfer_open (xfer_open), .bus_req (bus_req), .bus_ack (bus_ack),
    .ack_0 (ack_0), .ack_1 (ack_1), .rdata_0 (rdata_0), .rdata_1 (rdata_1),
    .busy_0 (busy_0), .busy_1 (busy_1)
);

`default_nettype wire

//--- bench/tb_shared_bus.sv
// testbench for the two-core shared bus, cores are played by tasks
// expects RAM_WORDS 64, so RAM word index is addr[7:2]
`timescale 1ns/10ps
`default_nettype none

module tb_shared_bus;
    import bus_pkg::*;

    localparam int SLOT = 4;
    localparam int MAX_WAIT = 200;
    localparam addr_t TMR = 32'h8000_0000;

    logic CLK, RST_X, req_0, we_0, idle_0, req_1, we_1, idle_1;
    addr_t addr_0, addr_1;
    data_t wdata_0, wdata_1, rdata_0, rdata_1, rd, rd_b, t0, t1;
    logic ack_0, ack_1, busy_0, busy_1, timer_irq;
    data_t exp_mem [64];
    addr_t wr_addr [6];
    integer seed = 71;
    int errors = 0, tests = 0, e0, n;

    shared_bus_top #(.RAM_WORDS(64), .SLOT_CYCLES(SLOT)) uut (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic check_eq(input string name, input data_t exp, input data_t act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_eq(name, {31'b0, exp}, {31'b0, act});
    endtask

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s: %s", name, (errors == e0) ? "ok" : "errors");
        e0 = errors;
    endtask

    task automatic wait_busy_low(input int core);
        int k;
        k = 0;
        @(negedge CLK);
        while (((core == 0) ? busy_0 : busy_1) && k < MAX_WAIT) begin
            @(negedge CLK);
            k++;
        end
        if ((core == 0) ? busy_0 : busy_1) abort_run("busy to fall");
    endtask

    // one four-phase access, driven on falling edges
    task automatic bus_access(input int core, input logic wr, input addr_t a,
                              input data_t d, output data_t r);
        int k;
        wait_busy_low(core);
        if (core == 0) begin
            req_0 = 1'b1;
            we_0 = wr;
            addr_0 = a;
            wdata_0 = d;
        end else begin
            req_1 = 1'b1;
            we_1 = wr;
            addr_1 = a;
            wdata_1 = d;
        end
        k = 0;
        do begin
            @(negedge CLK);
            k++;
        end while (!((core == 0) ? ack_0 : ack_1) && k < MAX_WAIT);
        if (!((core == 0) ? ack_0 : ack_1)) abort_run("ack to rise");
        r = (core == 0) ? rdata_0 : rdata_1;
        if (core == 0) req_0 = 1'b0;
        else req_1 = 1'b0;
        k = 0;
        do begin
            @(negedge CLK);
            k++;
        end while (((core == 0) ? ack_0 : ack_1) && k < MAX_WAIT);
        if ((core == 0) ? ack_0 : ack_1) abort_run("ack to fall");
    endtask

    initial begin
        {RST_X, req_0, we_0, idle_0, req_1, we_1, idle_1} = '0;
        {addr_0, addr_1, wdata_0, wdata_1} = '0;
        e0 = 0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RST_X = 1'b1;
        check_bit("reset busy_0", 1'b0, busy_0);
        check_bit("reset busy_1", 1'b1, busy_1);
        check_bit("reset irq", 1'b0, timer_irq);

        // core 0 writes, upper address bits vary so aliases land on the same words
        for (int i = 0; i < 6; i++) begin
            wr_addr[i] = {1'b0, 23'($random(seed)), 6'(i * 11), 2'b00};
            t0 = $random(seed);
            exp_mem[wr_addr[i][7:2]] = t0;
            bus_access(0, 1'b1, wr_addr[i], t0, rd);
        end
        end_test("ram_write");

        // handoff to core 1, which goes idle at once and hands back
        @(negedge CLK);
        idle_0 = 1'b1;
        @(negedge CLK);
        check_bit("handoff busy_0", 1'b1, busy_0);
        check_bit("handoff busy_1", 1'b1, busy_1);
        @(negedge CLK);
        check_bit("settle busy_1", 1'b1, busy_1);
        idle_0 = 1'b0;
        idle_1 = 1'b1;
        @(negedge CLK);
        check_bit("run busy_1", 1'b0, busy_1);
        // busy_0 has been high through both handoff cycles
        n = 2;
        while (busy_0 && n < MAX_WAIT) begin
            n++;
            @(negedge CLK);
        end
        if (busy_0) abort_run("core 0 to get the bus back");
        idle_1 = 1'b0;
        // both handoffs plus the full window and one serve cycle
        check_eq("slot window held", data_t'(SLOT + 5), data_t'(n));
        end_test("time_slice");

        // idle raised together with req must not start a handoff
        // the window has to run out first so that idle is looked at
        repeat (SLOT) @(negedge CLK);
        wait_busy_low(0);
        req_0 = 1'b1;
        we_0 = 1'b0;
        addr_0 = wr_addr[0];
        idle_0 = 1'b1;
        n = 0;
        do begin
            @(negedge CLK);
            check_bit("busy_0 in transfer", 1'b0, busy_0);
            n++;
        end while (!ack_0 && n < MAX_WAIT);
        if (!ack_0) abort_run("ack with idle raised");
        req_0 = 1'b0;
        @(negedge CLK);
        check_bit("busy_0 at ack fall", 1'b0, busy_0);
        end_test("no_mid_handoff");

        // core 1 reads back through other aliases after the handoff
        for (int i = 0; i < 6; i++) begin
            t0 = wr_addr[i] ^ 32'h0000_1f00;
            bus_access(1, 1'b0, t0, '0, rd);
            check_eq("ram_read", exp_mem[t0[7:2]], rd);
        end
        idle_0 = 1'b0;
        end_test("ram_round_trip");

        bus_access(1, 1'b0, TMR | TIMER_MTIME_LO, '0, t0);
        bus_access(1, 1'b0, TMR | TIMER_MTIME_LO, '0, t1);
        check_bit("mtime increases", 1'b1, t1 > t0);
        bus_access(1, 1'b1, TMR | TIMER_CMP_LO, t1 + 32'd40, rd);
        bus_access(1, 1'b1, TMR | TIMER_CMP_HI, '0, rd);
        n = 0;
        while (!timer_irq && n < MAX_WAIT) begin
            @(negedge CLK);
            n++;
        end
        if (!timer_irq) begin
            $display("timer_irq did not rise after the compare was reached");
            errors++;
        end
        bus_access(1, 1'b0, TMR | TIMER_CMP_LO, '0, rd);
        check_eq("cmp_lo read", t1 + 32'd40, rd);
        bus_access(1, 1'b0, TMR | TIMER_CMP_HI, '0, rd);
        check_eq("cmp_hi read", '0, rd);
        bus_access(1, 1'b1, TMR | TIMER_CMP_LO, '1, rd);
        bus_access(1, 1'b1, TMR | TIMER_CMP_HI, '1, rd);
        @(negedge CLK);
        check_bit("irq cleared", 1'b0, timer_irq);
        end_test("timer");

        // both cores request, core 0 waits for core 1 to hand over
        t0 = $random(seed);
        fork
            begin
                bus_access(1, 1'b1, 32'h0000_0028, t0, rd);
                idle_1 = 1'b1;
            end
            bus_access(0, 1'b0, 32'h0000_0028, '0, rd_b);
        join
        idle_1 = 1'b0;
        check_eq("shared_read", t0, rd_b);
        end_test("exclusive");

        $display("tests run %0d, check failures %0d, assertion failures %0d",
                 tests, errors, uut.chk.fail_count);
        if (errors == 0 && uut.chk.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/bus_pkg.sv
verilog/bus_arbiter.sv
verilog/bus_decode.sv
verilog/bus_execute.sv
verilog/bus_result.sv
verilog/shared_bus_top.sv
bench/shared_bus_checker.sv
bench/tb_shared_bus.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_shared_bus
FILELIST   ?= verilog.f
PASS_MSG   := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf obj_dir
